// File: lsu_config.svh
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// Register and byte address width
`define XLEN 32

// Data memory size in 32-bit words
`define MEM_DEPTH_WORDS 256

// Idle cycles between seeing mem_req and answering it
`define MEM_WAIT_CYCLES 2

`endif

// File: rv_isa_pkg.sv
`include "lsu_config.svh"

package rv_isa_pkg;

    //////////////////////////////
    // Instruction fields

    // Major opcode, inst[6:0]
    typedef logic [6:0] opcode_t;

    // Access width code, inst[14:12]
    typedef logic [2:0] funct3_t;

    //////////////////////////////
    // Register file values

    typedef logic [`XLEN-1:0] xaddr_t;
    typedef logic [`XLEN-1:0] xdata_t;

    //////////////////////////////
    // Encodings

    // Only the integer load and store majors
    localparam opcode_t OPC_LOAD  = 7'b00_000_11;
    localparam opcode_t OPC_STORE = 7'b01_000_11;

    // Bit 2 set means zero extension
    localparam funct3_t F3_BYTE   = 3'b000;
    localparam funct3_t F3_HALF   = 3'b001;
    localparam funct3_t F3_WORD   = 3'b010;
    localparam funct3_t F3_BYTE_U = 3'b100;
    localparam funct3_t F3_HALF_U = 3'b101;

endpackage

// File: mem_bus_pkg.sv
`include "lsu_config.svh"

package mem_bus_pkg;

    // Word index into the data memory
    typedef logic [$clog2(`MEM_DEPTH_WORDS)-1:0] word_addr_t;

    // One enable per byte lane, bit i covers bits 8i+7:8i
    typedef logic [3:0] byte_mask_t;

    typedef logic [`XLEN-1:0] mem_word_t;

endpackage

// File: lsu_lane_align.sv
`timescale 1ns/1ps

module lsu_lane_align
    import rv_isa_pkg::*;
    import mem_bus_pkg::*;
(
    input  opcode_t    opcode,
    input  funct3_t    funct3,
    input  xaddr_t     address,
    input  xdata_t     store_data,
    input  mem_word_t  mem_rdata,
    output logic       is_write,
    output word_addr_t mem_addr,
    output byte_mask_t mem_mask,
    output mem_word_t  mem_wdata,
    output xdata_t     load_data,
    output logic       fault
);

    localparam int ADDR_W = $bits(word_addr_t);

    logic      is_load;
    logic      is_store;
    logic      enc_ok;
    logic      misaligned;
    mem_word_t shifted;

    assign is_load  = (opcode == OPC_LOAD);
    assign is_store = (opcode == OPC_STORE);
    assign is_write = is_store;
    assign mem_addr = address[ADDR_W+1:2];

    //////////////////////////////
    // Access checking

    always_comb
    begin
        case (funct3)
            F3_BYTE, F3_HALF, F3_WORD: enc_ok = is_load || is_store;
            F3_BYTE_U, F3_HALF_U:      enc_ok = is_load;
            default:                   enc_ok = 1'b0;
        endcase

        case (funct3)
            F3_HALF, F3_HALF_U: misaligned = address[0];
            F3_WORD:            misaligned = |address[1:0];
            default:            misaligned = 1'b0;
        endcase
    end

    assign fault = !enc_ok || misaligned;

    //////////////////////////////
    // Lane placement

    // Store data is copied to every lane, the mask picks which land
    always_comb
    begin
        case (funct3)
            F3_BYTE, F3_BYTE_U:
            begin
                mem_mask  = byte_mask_t'(4'b0001 << address[1:0]);
                mem_wdata = {4{store_data[7:0]}};
            end
            F3_HALF, F3_HALF_U:
            begin
                mem_mask  = address[1] ? 4'b1100 : 4'b0011;
                mem_wdata = {2{store_data[15:0]}};
            end
            F3_WORD:
            begin
                mem_mask  = 4'b1111;
                mem_wdata = store_data;
            end
            default:
            begin
                mem_mask  = 4'b0000;
                mem_wdata = store_data;
            end
        endcase
    end

    // Addressed lane moved down to bit 0
    assign shifted = mem_rdata >> {address[1:0], 3'b000};

    always_comb
    begin
        case (funct3)
            F3_BYTE:   load_data = {{24{shifted[7]}}, shifted[7:0]};
            F3_BYTE_U: load_data = {24'b0, shifted[7:0]};
            F3_HALF:   load_data = {{16{shifted[15]}}, shifted[15:0]};
            F3_HALF_U: load_data = {16'b0, shifted[15:0]};
            F3_WORD:   load_data = mem_rdata;
            default:   load_data = '0;
        endcase
    end

endmodule

// File: load_store_unit.sv
`timescale 1ns/1ps

module load_store_unit
    import rv_isa_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cpu_req,
    input  opcode_t    opcode,
    input  funct3_t    funct3,
    input  xaddr_t     address,
    input  xdata_t     store_data,
    input  logic       mem_ack,
    input  mem_word_t  mem_rdata,
    output logic       cpu_ack,
    output xdata_t     load_data,
    output logic       fault,
    output logic       mem_req,
    output logic       mem_write,
    output word_addr_t mem_addr,
    output byte_mask_t mem_mask,
    output mem_word_t  mem_wdata
);

    typedef enum logic [1:0]
    {
        ST_IDLE,
        ST_MEM,
        ST_RELEASE,
        ST_DONE
    } lsu_state_t;

    lsu_state_t state;
    logic       pending;
    logic       capture;
    opcode_t    req_opcode;
    funct3_t    req_funct3;
    xaddr_t     req_address;
    xdata_t     req_store_data;
    xdata_t     align_load_data;
    logic       align_fault;

    assign capture = (state == ST_IDLE) && !pending && cpu_req;

    // Held request keeps the memory side stable
    always_ff @(posedge clk)
    begin
        if (capture)
        begin
            req_opcode     <= opcode;
            req_funct3     <= funct3;
            req_address    <= address;
            req_store_data <= store_data;
        end
    end

    lsu_lane_align lsu_lane_align_inst
    (
        .opcode     (req_opcode),
        .funct3     (req_funct3),
        .address    (req_address),
        .store_data (req_store_data),
        .mem_rdata  (mem_rdata),
        .is_write   (mem_write),
        .mem_addr   (mem_addr),
        .mem_mask   (mem_mask),
        .mem_wdata  (mem_wdata),
        .load_data  (align_load_data),
        .fault      (align_fault)
    );

    //////////////////////////////
    // Handshake FSM

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state     <= ST_IDLE;
            pending   <= 1'b0;
            cpu_ack   <= 1'b0;
            fault     <= 1'b0;
            mem_req   <= 1'b0;
            load_data <= '0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    if (pending)
                    begin
                        pending <= 1'b0;
                        if (align_fault)
                        begin
                            // Rejected, memory is left alone
                            cpu_ack   <= 1'b1;
                            fault     <= 1'b1;
                            load_data <= '0;
                            state     <= ST_DONE;
                        end
                        else
                        begin
                            mem_req <= 1'b1;
                            state   <= ST_MEM;
                        end
                    end
                    else if (capture)
                    begin
                        pending <= 1'b1;
                    end
                end
                ST_MEM:
                begin
                    if (mem_ack)
                    begin
                        mem_req   <= 1'b0;
                        load_data <= mem_write ? '0 : align_load_data;
                        state     <= ST_RELEASE;
                    end
                end
                ST_RELEASE:
                begin
                    if (!mem_ack)
                    begin
                        cpu_ack <= 1'b1;
                        fault   <= 1'b0;
                        state   <= ST_DONE;
                    end
                end
                ST_DONE:
                begin
                    if (!cpu_req)
                    begin
                        cpu_ack <= 1'b0;
                        fault   <= 1'b0;
                        state   <= ST_IDLE;
                    end
                end
                default:
                begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Memory must drop its ack before the next request
    a_no_req_under_ack: assert property (@(posedge clk) disable iff (!rst_n)
        mem_ack && !mem_req |=> !mem_req)
        else $error("mem_req raised while mem_ack still high");

    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req && $past(mem_req)
        |-> $stable({req_opcode, req_funct3, req_address, req_store_data}))
        else $error("request changed during memory handshake");

endmodule

// File: data_memory.sv
`timescale 1ns/1ps

`include "lsu_config.svh"

module data_memory
    import mem_bus_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       mem_req,
    input  logic       mem_write,
    input  word_addr_t mem_addr,
    input  byte_mask_t mem_mask,
    input  mem_word_t  mem_wdata,
    output logic       mem_ack,
    output mem_word_t  mem_rdata
);

    localparam int WAIT_W = $clog2(`MEM_WAIT_CYCLES + 2);
    localparam logic [WAIT_W-1:0] ACK_COUNT = WAIT_W'(`MEM_WAIT_CYCLES + 1);

    mem_word_t         mem_array [`MEM_DEPTH_WORDS];
    logic [WAIT_W-1:0] wait_cnt;
    logic              do_access;

    initial
    begin
        for (int i = 0; i < `MEM_DEPTH_WORDS; i++)
        begin
            mem_array[i] = '0;
        end
    end

    // Last wait edge performs the access
    assign do_access = mem_req && !mem_ack && (wait_cnt == ACK_COUNT);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            mem_ack  <= 1'b0;
            wait_cnt <= '0;
        end
        else if (!mem_req)
        begin
            mem_ack  <= 1'b0;
            wait_cnt <= '0;
        end
        else if (do_access)
        begin
            mem_ack <= 1'b1;
        end
        else if (!mem_ack)
        begin
            wait_cnt <= wait_cnt + WAIT_W'(1);
        end
    end

    //////////////////////////////
    // Storage

    always_ff @(posedge clk)
    begin
        if (do_access)
        begin
            if (mem_write)
            begin
                for (int i = 0; i < 4; i++)
                begin
                    if (mem_mask[i])
                    begin
                        mem_array[mem_addr][8*i +: 8] <= mem_wdata[8*i +: 8];
                    end
                end
            end
            else
            begin
                mem_rdata <= mem_array[mem_addr];
            end
        end
    end

    // Requester must still hold mem_req when the ack shows up
    a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(mem_ack) |-> mem_req)
        else $error("mem_ack rose with no request");

    // Faulting accesses never reach here
    a_mask_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req |-> mem_mask != '0)
        else $error("empty byte mask on a memory request");

endmodule

// File: lsu_subsystem.sv
`timescale 1ns/1ps

module lsu_subsystem
    import rv_isa_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    cpu_req,
    input  opcode_t opcode,
    input  funct3_t funct3,
    input  xaddr_t  address,
    input  xdata_t  store_data,
    output logic    cpu_ack,
    output xdata_t  load_data,
    output logic    fault
);

    //////////////////////////////
    // Memory handshake

    logic       mem_req;
    logic       mem_write;
    word_addr_t mem_addr;
    byte_mask_t mem_mask;
    mem_word_t  mem_wdata;
    logic       mem_ack;
    mem_word_t  mem_rdata;

    load_store_unit load_store_unit_inst
    (
        .clk        (clk),
        .rst_n      (rst_n),
        .cpu_req    (cpu_req),
        .opcode     (opcode),
        .funct3     (funct3),
        .address    (address),
        .store_data (store_data),
        .mem_ack    (mem_ack),
        .mem_rdata  (mem_rdata),
        .cpu_ack    (cpu_ack),
        .load_data  (load_data),
        .fault      (fault),
        .mem_req    (mem_req),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_mask   (mem_mask),
        .mem_wdata  (mem_wdata)
    );

    data_memory data_memory_inst
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_req   (mem_req),
        .mem_write (mem_write),
        .mem_addr  (mem_addr),
        .mem_mask  (mem_mask),
        .mem_wdata (mem_wdata),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

endmodule

// File: lsu_tb.sv
`timescale 1ns/1ps

`include "lsu_config.svh"

module lsu_tb
    import rv_isa_pkg::*;
();

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 4;
    localparam int MAX_TESTS    = 64;
    localparam int FIELDS       = 6;
    localparam int MAX_WAIT     = 3;

    // Bound for one access, with room for the longest hold and idle
    localparam int CYCLES_PER_TEST = `MEM_WAIT_CYCLES + 12 + 2 * MAX_WAIT;

    logic    clk;
    logic    rst_n;
    logic    cpu_req;
    opcode_t opcode;
    funct3_t funct3;
    xaddr_t  address;
    xdata_t  store_data;
    logic    cpu_ack;
    xdata_t  load_data;
    logic    fault;

    logic [31:0] test_mem [0:FIELDS*MAX_TESTS-1];
    int          num_tests;
    integer      seed;

    lsu_subsystem lsu_subsystem_inst
    (
        .clk        (clk),
        .rst_n      (rst_n),
        .cpu_req    (cpu_req),
        .opcode     (opcode),
        .funct3     (funct3),
        .address    (address),
        .store_data (store_data),
        .cpu_ack    (cpu_ack),
        .load_data  (load_data),
        .fault      (fault)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("[FAIL] %0t %s: got %h, expected %h", $time, name, actual, expected);
            $display("** FAIL **");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    //////////////////////////////
    // One access

    task automatic run_test(input int idx);
        logic [31:0] vec_opcode;
        logic [31:0] vec_funct3;
        logic [31:0] vec_address;
        logic [31:0] vec_store;
        logic [31:0] exp_data;
        logic [31:0] exp_fault;
        int          hold_cycles;
        int          idle_cycles;

        vec_opcode  = test_mem[FIELDS*idx];
        vec_funct3  = test_mem[FIELDS*idx + 1];
        vec_address = test_mem[FIELDS*idx + 2];
        vec_store   = test_mem[FIELDS*idx + 3];
        exp_data    = test_mem[FIELDS*idx + 4];
        exp_fault   = test_mem[FIELDS*idx + 5];

        cpu_req    <= 1'b1;
        opcode     <= vec_opcode[6:0];
        funct3     <= vec_funct3[2:0];
        address    <= vec_address;
        store_data <= vec_store;

        do
        begin
            @(posedge clk);
        end
        while (!cpu_ack);

        check_value("fault", {31'b0, fault}, {31'b0, exp_fault[0]});
        if (vec_opcode[6:0] == OPC_LOAD)
        begin
            check_value("load_data", load_data, exp_data);
        end

        // Ack must stay up while the request is held
        hold_cycles = $unsigned($random(seed)) % (MAX_WAIT + 1);
        repeat (hold_cycles)
        begin
            @(posedge clk);
            check_value("cpu_ack", {31'b0, cpu_ack}, 32'd1);
        end

        cpu_req <= 1'b0;
        do
        begin
            @(posedge clk);
        end
        while (cpu_ack);

        idle_cycles = $unsigned($random(seed)) % (MAX_WAIT + 1);
        repeat (idle_cycles)
        begin
            @(posedge clk);
        end
    endtask

    //////////////////////////////
    // Main sequence

    initial
    begin
        rst_n      = 1'b0;
        cpu_req    = 1'b0;
        opcode     = '0;
        funct3     = '0;
        address    = '0;
        store_data = '0;
        seed       = 96;
        num_tests  = 0;

        for (int i = 0; i < FIELDS*MAX_TESTS; i++)
        begin
            test_mem[i] = '1;
        end
        $readmemh("lsu_tests.txt", test_mem);

        // An all-ones opcode marks the end of the vectors
        while (num_tests < MAX_TESTS && test_mem[FIELDS*num_tests] != 32'hffff_ffff)
        begin
            num_tests++;
        end
        if (num_tests == 0)
        begin
            $display("No test vectors could be read from lsu_tests.txt");
            $display("** FAIL **");
            $fatal(1, "empty test file");
        end

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_value("cpu_ack", {31'b0, cpu_ack}, 32'd0);

        for (int t = 0; t < num_tests; t++)
        begin
            run_test(t);
        end

        $display("** PASS **");
        $finish;
    end

    initial
    begin
        wait (rst_n === 1'b1);
        repeat (num_tests * CYCLES_PER_TEST + RESET_CYCLES) @(posedge clk);
        $display("Timeout, the handshake did not complete in time");
        $display("** FAIL **");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: lsu_tests.txt
// opcode funct3 address store_data expected_load_data expected_fault
// opcode 03 is LOAD, 23 is STORE, anything else is unsupported
23 2 00000040 deadbeef 00000000 0
23 2 00000044 12345678 00000000 0
03 2 00000040 00000000 deadbeef 0
03 2 00000044 00000000 12345678 0
23 0 00000080 ffffff11 00000000 0
23 0 00000081 00000082 00000000 0
23 0 00000082 00000033 00000000 0
23 0 00000083 000000f4 00000000 0
03 2 00000080 00000000 f4338211 0
03 0 00000081 00000000 ffffff82 0
03 4 00000081 00000000 00000082 0
03 0 00000083 00000000 fffffff4 0
03 4 00000083 00000000 000000f4 0
23 2 000000c0 11223344 00000000 0
23 1 000000c0 abcd8001 00000000 0
03 2 000000c0 00000000 11228001 0
23 1 000000c2 00009abc 00000000 0
03 2 000000c0 00000000 9abc8001 0
03 1 000000c0 00000000 ffff8001 0
03 5 000000c0 00000000 00008001 0
03 1 000000c2 00000000 ffff9abc 0
03 5 000000c2 00000000 00009abc 0
23 1 000000c1 00005555 00000000 1
23 2 00000042 cafef00d 00000000 1
03 2 00000041 00000000 00000000 1
03 2 000000c0 00000000 9abc8001 0
03 2 00000040 00000000 deadbeef 0
13 0 00000040 00000000 00000000 1
23 4 00000040 00000000 00000000 1
23 5 00000044 00000000 00000000 1
03 3 00000040 00000000 00000000 1
03 2 00000040 00000000 deadbeef 0
03 2 00000044 00000000 12345678 0

// File: filelist.f
+incdir+.
rv_isa_pkg.sv
mem_bus_pkg.sv
lsu_lane_align.sv
load_store_unit.sv
data_memory.sv
lsu_subsystem.sv
lsu_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --assert
TOP       := lsu_tb
FILELIST  := filelist.f
BUILD_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
